// File: Bender.yml
package:
  name: udp_pattern_source

sources:
  - source/cmd_pkg.sv
  - source/stream_pkg.sv
  - source/cmd_rx_filter.sv
  - source/cmd_decoder.sv
  - source/pattern_burst_gen.sv
  - source/tx_frame_buffer.sv
  - source/udp_pattern_source.sv
  - target: test
    files:
      - dv/tb_udp_pattern_source.sv

// File: dv/tb_udp_pattern_source.sv
// Testbench for the UDP pattern source: command frames, bursts, scoreboard
// and protocol assertions on the transmit handshakes
`timescale 1ns/1ps
`default_nettype none

module tb_udp_pattern_source;
    import stream_pkg::*;

    localparam logic [31:0] IP_A = {8'd10, 8'd0, 8'd0, 8'd7};
    localparam logic [31:0] IP_B = {8'd172, 8'd16, 8'd3, 8'd21};
    localparam logic [15:0] OTHER_PORT = 16'd4321;
    localparam int WINDOW      = 40;
    localparam int FRAME_WORDS = 20;
    localparam int BURST_WORDS = (4 + 2 + 3) * PKT_WORDS;
    localparam int MAX_CYCLES  = 2 * (FRAME_WORDS + BURST_WORDS) + 800;

    logic        clk = 1'b0;
    logic        rst;
    logic        rx_hdr_valid;
    wire         rx_hdr_ready;
    logic [15:0] rx_dest_port;
    logic [31:0] rx_source_ip;
    logic        rx_payload_valid;
    wire         rx_payload_ready;
    logic [63:0] rx_payload_data;
    logic        rx_payload_last;
    wire         tx_hdr_valid;
    logic        tx_hdr_ready;
    wire  [31:0] tx_dest_ip;
    wire         tx_payload_valid;
    logic        tx_payload_ready;
    wire  [63:0] tx_payload_data;
    wire         tx_payload_last;
    wire         armed;

    integer      seed = 32'h5caf9b0d;
    logic [31:0] rand_word;
    logic        backpressure = 1'b0;
    int          cycle_count = 0;
    int          check_errors = 0;
    int          scoreboard_errors = 0;
    int          protocol_errors = 0;

    // Scoreboard state
    logic [31:0] exp_ip = DEFAULT_DEST_IP;
    logic [63:0] word_tally = '0;
    logic [63:0] burst_first_word = '0;
    wire  [63:0] exp_data = word_tally - burst_first_word;
    int          word_idx = 0;
    int          pkt_tally = 0;
    int          hdr_tally = 0;
    logic        in_packet = 1'b0;

    udp_pattern_source uut (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_dest_port     (rx_dest_port),
        .rx_source_ip     (rx_source_ip),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_last  (rx_payload_last),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_dest_ip       (tx_dest_ip),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload_data  (tx_payload_data),
        .tx_payload_last  (tx_payload_last),
        .armed            (armed)
    );

    always #50 clk = ~clk;

    // ASCII text packed little endian, first character in the low byte
    function automatic logic [63:0] ascii_le(input string text);
        logic [63:0] word;
        word = '0;
        for (int i = 0; i < text.len(); i++) begin
            word[8*i +: 8] = text[i];
        end
        return word;
    endfunction

    // Count goes out most significant byte first, starting at byte 4
    function automatic logic [63:0] pkt_command(input logic [31:0] count);
        logic [63:0] word;
        word = ascii_le("PKT#");
        word[39:32] = count[31:24];
        word[47:40] = count[23:16];
        word[55:48] = count[15:8];
        word[63:56] = count[7:0];
        return word;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            check_errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input logic [15:0] port, input logic [31:0] src_ip,
                              input logic [63:0] words[$]);
        rx_hdr_valid = 1'b1;
        rx_dest_port = port;
        rx_source_ip = src_ip;
        do @(posedge clk); while (!rx_hdr_ready);
        #1;
        rx_hdr_valid = 1'b0;
        foreach (words[i]) begin
            rx_payload_valid = 1'b1;
            rx_payload_data  = words[i];
            rx_payload_last  = (i == words.size() - 1);
            do @(posedge clk); while (!rx_payload_ready);
            #1;
        end
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
    endtask

    // Command word plus one filler word, so the drain path is used too
    task automatic send_command(input logic [15:0] port, input logic [31:0] src_ip,
                                input logic [63:0] cmd);
        logic [63:0] words[$];
        words.push_back(cmd);
        words.push_back(64'hA5A5_0000_0000_5A5A);
        send_frame(port, src_ip, words);
        idle_cycles(3);
    endtask

    task automatic wait_packets(input int target);
        while (pkt_tally < target) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // Transmit side readiness, random under back-pressure
    always @(posedge clk) begin
        #1;
        if (backpressure) begin
            rand_word        = $random(seed);
            tx_hdr_ready     = rand_word[4];
            tx_payload_ready = (rand_word[1:0] == 2'b00);
        end else begin
            tx_hdr_ready     = 1'b1;
            tx_payload_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            assert (!in_packet) else begin
                scoreboard_errors++;
                $display("Header accepted while a packet was still open");
            end
            assert (tx_dest_ip == exp_ip) else begin
                scoreboard_errors++;
                $display("MISMATCH tx_dest_ip: got %h, expected %h", tx_dest_ip, exp_ip);
            end
            in_packet = 1'b1;
            hdr_tally++;
        end
        if (!rst && tx_payload_valid && tx_payload_ready) begin
            assert (in_packet) else begin
                scoreboard_errors++;
                $display("Payload word accepted before its header");
            end
            assert (tx_payload_data == exp_data) else begin
                scoreboard_errors++;
                $display("MISMATCH tx_payload_data: got %h, expected %h",
                         tx_payload_data, exp_data);
            end
            assert (tx_payload_last == (word_idx == PKT_WORDS - 1)) else begin
                scoreboard_errors++;
                $display("MISMATCH tx_payload_last: got %h, expected %h",
                         tx_payload_last, (word_idx == PKT_WORDS - 1));
            end
            word_tally++;
            if (word_idx == PKT_WORDS - 1) begin
                word_idx  = 0;
                pkt_tally++;
                in_packet = 1'b0;
            end else begin
                word_idx++;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=>
            tx_payload_valid && $stable(tx_payload_data) && $stable(tx_payload_last))
    else begin
        protocol_errors++;
        $display("Stalled tx payload word changed or was withdrawn");
    end

    assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid)
    else begin
        protocol_errors++;
        $display("Pending tx header was withdrawn before acceptance");
    end

    assert property (@(posedge clk) disable iff (rst) !(rx_hdr_ready && rx_payload_ready))
    else begin
        protocol_errors++;
        $display("Receive header and payload were ready at the same time");
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not complete", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rst              = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_dest_port     = '0;
        rx_source_ip     = '0;
        rx_payload_valid = 1'b0;
        rx_payload_data  = '0;
        rx_payload_last  = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        idle_cycles(16);
        rst = 1'b0;
        check_value("rx_hdr_ready", rx_hdr_ready, 1);
        check_value("rx_payload_ready", rx_payload_ready, 0);
        check_value("tx_hdr_valid", tx_hdr_valid, 0);
        check_value("tx_payload_valid", tx_payload_valid, 0);
        check_value("armed", armed, 0);
        check_value("tx_dest_ip", tx_dest_ip, DEFAULT_DEST_IP);

        // Commands to another port go nowhere
        send_command(OTHER_PORT, IP_A, ascii_le("....INIT"));
        send_command(OTHER_PORT, IP_A, ascii_le("TRIGGER_"));
        idle_cycles(WINDOW);
        check_value("armed", armed, 0);
        check_value("tx_dest_ip", tx_dest_ip, DEFAULT_DEST_IP);
        check_value("hdr_tally", hdr_tally, 0);

        // Arm from A, default burst
        exp_ip = IP_A;
        send_command(CMD_PORT, IP_A, ascii_le("....INIT"));
        check_value("armed", armed, 1);
        check_value("tx_dest_ip", tx_dest_ip, IP_A);
        burst_first_word = word_tally;
        send_command(CMD_PORT, IP_A, ascii_le("TRIGGER_"));
        wait_packets(DEFAULT_PKT_COUNT);
        check_value("hdr_tally", hdr_tally, DEFAULT_PKT_COUNT);

        // Two packets per burst, commanded from B
        exp_ip = IP_B;
        send_command(CMD_PORT, IP_B, pkt_command(32'd2));
        burst_first_word = word_tally;
        send_command(CMD_PORT, IP_B, ascii_le("TRIGGER_"));
        wait_packets(DEFAULT_PKT_COUNT + 2);
        idle_cycles(WINDOW);
        check_value("pkt_tally", pkt_tally, DEFAULT_PKT_COUNT + 2);
        check_value("hdr_tally", hdr_tally, DEFAULT_PKT_COUNT + 2);

        // Three packets against a slow, random sink
        send_command(CMD_PORT, IP_B, pkt_command(32'd3));
        backpressure = 1'b1;
        burst_first_word = word_tally;
        send_command(CMD_PORT, IP_B, ascii_le("TRIGGER_"));
        wait_packets(DEFAULT_PKT_COUNT + 5);
        backpressure = 1'b0;
        idle_cycles(4);
        check_value("hdr_tally", hdr_tally, DEFAULT_PKT_COUNT + 5);

        // Disarmed source ignores the trigger
        send_command(CMD_PORT, IP_B, ascii_le("....FINI"));
        check_value("armed", armed, 0);
        send_command(CMD_PORT, IP_B, ascii_le("TRIGGER_"));
        idle_cycles(WINDOW);
        check_value("hdr_tally", hdr_tally, DEFAULT_PKT_COUNT + 5);

        $display("Errors: checks %0d, scoreboard %0d, protocol %0d",
                 check_errors, scoreboard_errors, protocol_errors);
        if (check_errors + scoreboard_errors + protocol_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/cmd_decoder.sv
// Command decoder producing armed state, burst packet count and trigger pulse
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cmd_valid,
    input  cmd_pkg::cmd_word_t                  cmd_word,
    output logic                                armed,
    output logic [cmd_pkg::PKT_COUNT_WIDTH-1:0] pkt_count,
    output logic                                trigger_pulse
);
    import cmd_pkg::*;
    import stream_pkg::*;

    logic [31:0] arg;
    logic [31:0] tag;

    assign arg = cmd_word.tagged_view.arg;
    assign tag = cmd_word.tagged_view.tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            armed         <= 1'b0;
            pkt_count     <= DEFAULT_PKT_COUNT;
            trigger_pulse <= 1'b0;
        end else begin
            trigger_pulse <= cmd_valid && (cmd_word.raw == TRIGGER_WORD);
            if (cmd_valid) begin
                if (tag == TAG_DOTS) begin
                    if (arg == ARG_INIT) begin
                        armed <= 1'b1;
                    end else if (arg == ARG_FINI) begin
                        armed <= 1'b0;
                    end
                end else if (tag == TAG_PKT) begin
                    // Count arrives most significant byte first
                    pkt_count <= {arg[7:0], arg[15:8], arg[23:16], arg[31:24]};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/cmd_pkg.sv
// Command word layout, command codes and the two-view command word union
`default_nettype none

package cmd_pkg;

    localparam int CMD_WIDTH       = 64;
    localparam int PKT_COUNT_WIDTH = 32;

    // Arg in the upper half, tag in the lower half
    typedef struct packed {
        logic [31:0] arg;
        logic [31:0] tag;
    } cmd_tagged_t;

    // Same word read as one 64-bit code or as tag plus arg
    typedef union packed {
        logic [CMD_WIDTH-1:0] raw;
        cmd_tagged_t          tagged_view;
    } cmd_word_t;

    // ASCII codes, little endian
    localparam logic [CMD_WIDTH-1:0] TRIGGER_WORD = 64'h5F52_4547_4749_5254;
    localparam logic [31:0] TAG_DOTS = 32'h2E2E_2E2E;
    localparam logic [31:0] ARG_INIT = 32'h5449_4E49;
    localparam logic [31:0] ARG_FINI = 32'h494E_4946;
    localparam logic [31:0] TAG_PKT  = 32'h2354_4B50;

endpackage

`default_nettype wire

// File: source/cmd_rx_filter.sv
// Receive side frame tracker with port match, sender address capture
// and first payload word extraction
`timescale 1ns/1ps
`default_nettype none

module cmd_rx_filter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rx_hdr_valid,
    output logic                           rx_hdr_ready,
    input  logic [15:0]                    rx_dest_port,
    input  logic [stream_pkg::IP_WIDTH-1:0]   rx_source_ip,
    input  logic                           rx_payload_valid,
    output logic                           rx_payload_ready,
    input  logic [stream_pkg::DATA_WIDTH-1:0] rx_payload_data,
    input  logic                           rx_payload_last,
    output logic                           cmd_valid,
    output cmd_pkg::cmd_word_t             cmd_word,
    output logic [stream_pkg::IP_WIDTH-1:0]   tx_dest_ip
);
    import stream_pkg::*;

    localparam logic [1:0] S_HDR   = 2'd0;
    localparam logic [1:0] S_FIRST = 2'd1;
    localparam logic [1:0] S_REST  = 2'd2;

    logic [1:0] state;
    logic       cmd_match;
    logic       hdr_fire;
    logic       pay_fire;

    assign rx_hdr_ready     = (state == S_HDR);
    assign rx_payload_ready = (state != S_HDR);
    assign hdr_fire         = rx_hdr_valid && rx_hdr_ready;
    assign pay_fire         = rx_payload_valid && rx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_HDR;
            cmd_match  <= 1'b0;
            cmd_valid  <= 1'b0;
            tx_dest_ip <= DEFAULT_DEST_IP;
        end else begin
            cmd_valid <= 1'b0;
            case (state)
                S_HDR: begin
                    if (hdr_fire) begin
                        cmd_match <= (rx_dest_port == CMD_PORT);
                        // Replies go back to whoever sent the command
                        if (rx_dest_port == CMD_PORT) begin
                            tx_dest_ip <= rx_source_ip;
                        end
                        state <= S_FIRST;
                    end
                end
                S_FIRST: begin
                    if (pay_fire) begin
                        cmd_valid <= cmd_match;
                        state     <= rx_payload_last ? S_HDR : S_REST;
                    end
                end
                default: begin
                    // Drain the rest of the frame
                    if (pay_fire && rx_payload_last) begin
                        state <= S_HDR;
                    end
                end
            endcase
        end
    end

    // First word only, held until the next command
    always_ff @(posedge clk) begin
        if (state == S_FIRST && pay_fire && cmd_match) begin
            cmd_word.raw <= rx_payload_data;
        end
    end

    // One command per frame
    assert property (@(posedge clk) disable iff (rst) cmd_valid |=> !cmd_valid);

endmodule

`default_nettype wire

// File: source/pattern_burst_gen.sv
// Burst FSM emitting counting words, with a last flag closing each packet
`timescale 1ns/1ps
`default_nettype none

module pattern_burst_gen #(
    parameter int words_per_pkt = stream_pkg::PKT_WORDS
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                armed,
    input  logic [cmd_pkg::PKT_COUNT_WIDTH-1:0] pkt_count,
    input  logic                                trigger_pulse,
    output logic                                gen_valid,
    input  logic                                gen_ready,
    output logic [stream_pkg::DATA_WIDTH-1:0]   gen_data,
    output logic                                gen_last
);
    import cmd_pkg::*;

    localparam int IDX_W = $clog2(words_per_pkt);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_STREAM = 2'd1;
    localparam logic [1:0] ST_LAST   = 2'd2;

    logic [1:0]                 state;
    logic [IDX_W-1:0]           word_idx;
    logic [PKT_COUNT_WIDTH-1:0] pkt_idx;
    logic [PKT_COUNT_WIDTH-1:0] burst_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            gen_valid <= 1'b0;
            gen_last  <= 1'b0;
            word_idx  <= '0;
            pkt_idx   <= '0;
            burst_len <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Triggers while disarmed, or for zero packets, do nothing
                    if (trigger_pulse && armed && pkt_count != '0) begin
                        state     <= ST_STREAM;
                        gen_valid <= 1'b1;
                        gen_last  <= 1'b0;
                        word_idx  <= '0;
                        pkt_idx   <= '0;
                        burst_len <= pkt_count;
                    end
                end
                ST_STREAM: begin
                    if (gen_ready) begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == IDX_W'(words_per_pkt - 2)) begin
                            gen_last <= 1'b1;
                            state    <= ST_LAST;
                        end
                    end
                end
                default: begin
                    if (gen_ready) begin
                        gen_last <= 1'b0;
                        word_idx <= '0;
                        if (pkt_idx == burst_len - 1'b1) begin
                            gen_valid <= 1'b0;
                            state     <= ST_IDLE;
                        end else begin
                            pkt_idx <= pkt_idx + 1'b1;
                            state   <= ST_STREAM;
                        end
                    end
                end
            endcase
        end
    end

    // Counter restarts per burst and runs on across packets
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            gen_data <= '0;
        end else if (gen_ready) begin
            gen_data <= gen_data + 1'b1;
        end
    end

    // Stalled word stays put
    assert property (@(posedge clk) disable iff (rst)
        gen_valid && !gen_ready |=> gen_valid && $stable(gen_data) && $stable(gen_last));

endmodule

`default_nettype wire

// File: source/stream_pkg.sv
// Stream widths, packet size, UDP port and address defaults, FIFO depth
`default_nettype none

package stream_pkg;

    localparam int DATA_WIDTH = 64;
    localparam int IP_WIDTH   = 32;

    // Packet geometry
    localparam int PKT_WORDS                = 16;
    localparam logic [31:0] DEFAULT_PKT_COUNT = 32'd4;

    // Frames to this port carry commands
    localparam logic [15:0] CMD_PORT = 16'd1234;

    // 192.168.1.100
    localparam logic [IP_WIDTH-1:0] DEFAULT_DEST_IP = {8'd192, 8'd168, 8'd1, 8'd100};

    localparam int FIFO_DEPTH = 32;

endpackage

`default_nettype wire

// File: source/tx_frame_buffer.sv
// Transmit word FIFO with last flag and per-packet UDP header framer
`timescale 1ns/1ps
`default_nettype none

module tx_frame_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              gen_valid,
    output logic                              gen_ready,
    input  logic [stream_pkg::DATA_WIDTH-1:0] gen_data,
    input  logic                              gen_last,
    output logic                              tx_hdr_valid,
    input  logic                              tx_hdr_ready,
    output logic                              tx_payload_valid,
    input  logic                              tx_payload_ready,
    output logic [stream_pkg::DATA_WIDTH-1:0] tx_payload_data,
    output logic                              tx_payload_last
);
    import stream_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    // Each entry is {last, data}
    logic [DATA_WIDTH:0] mem [FIFO_DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] occupancy;
    logic        full;
    logic        empty;
    logic        wr_en;
    logic        rd_en;
    logic        in_pkt;

    assign occupancy = wr_ptr - rd_ptr;
    assign full      = (occupancy == (AW + 1)'(FIFO_DEPTH));
    assign empty     = (wr_ptr == rd_ptr);

    assign gen_ready = !full;
    assign wr_en     = gen_valid && gen_ready;

    // Header first, then the payload path opens for one packet
    assign tx_hdr_valid     = !in_pkt && !empty;
    assign tx_payload_valid = in_pkt && !empty;
    assign rd_en            = tx_payload_valid && tx_payload_ready;

    assign tx_payload_data = mem[rd_ptr[AW-1:0]][DATA_WIDTH-1:0];
    assign tx_payload_last = mem[rd_ptr[AW-1:0]][DATA_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {gen_last, gen_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            in_pkt <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                in_pkt <= 1'b1;
            end else if (rd_en && tx_payload_last) begin
                in_pkt <= 1'b0;
            end
        end
    end

    // A write never lands on the slot of an unread entry
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (wr_ptr[AW] == rd_ptr[AW]) || (wr_ptr[AW-1:0] != rd_ptr[AW-1:0]));

    // After a packet's last word the next payload waits for its own header
    assert property (@(posedge clk) disable iff (rst)
        rd_en && tx_payload_last |=> !tx_payload_valid);

endmodule

`default_nettype wire

// File: source/udp_pattern_source.sv
// Top level joining receive filter, command decoder, burst generator
// and transmit buffer
`timescale 1ns/1ps
`default_nettype none

module udp_pattern_source (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rx_hdr_valid,
    output logic                              rx_hdr_ready,
    input  logic [15:0]                       rx_dest_port,
    input  logic [stream_pkg::IP_WIDTH-1:0]   rx_source_ip,
    input  logic                              rx_payload_valid,
    output logic                              rx_payload_ready,
    input  logic [stream_pkg::DATA_WIDTH-1:0] rx_payload_data,
    input  logic                              rx_payload_last,
    output logic                              tx_hdr_valid,
    input  logic                              tx_hdr_ready,
    output logic [stream_pkg::IP_WIDTH-1:0]   tx_dest_ip,
    output logic                              tx_payload_valid,
    input  logic                              tx_payload_ready,
    output logic [stream_pkg::DATA_WIDTH-1:0] tx_payload_data,
    output logic                              tx_payload_last,
    output logic                              armed
);
    import cmd_pkg::*;
    import stream_pkg::*;

    logic                       cmd_valid;
    cmd_word_t                  cmd_word;
    logic [PKT_COUNT_WIDTH-1:0] pkt_count;
    logic                       trigger_pulse;
    logic                       gen_valid;
    logic                       gen_ready;
    logic [DATA_WIDTH-1:0]      gen_data;
    logic                       gen_last;

    cmd_rx_filter u_filter (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_dest_port     (rx_dest_port),
        .rx_source_ip     (rx_source_ip),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_last  (rx_payload_last),
        .cmd_valid        (cmd_valid),
        .cmd_word         (cmd_word),
        .tx_dest_ip       (tx_dest_ip)
    );

    cmd_decoder u_decoder (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd_word      (cmd_word),
        .armed         (armed),
        .pkt_count     (pkt_count),
        .trigger_pulse (trigger_pulse)
    );

    pattern_burst_gen #(
        .words_per_pkt (PKT_WORDS)
    ) u_gen (
        .clk           (clk),
        .rst           (rst),
        .armed         (armed),
        .pkt_count     (pkt_count),
        .trigger_pulse (trigger_pulse),
        .gen_valid     (gen_valid),
        .gen_ready     (gen_ready),
        .gen_data      (gen_data),
        .gen_last      (gen_last)
    );

    tx_frame_buffer u_txbuf (
        .clk              (clk),
        .rst              (rst),
        .gen_valid        (gen_valid),
        .gen_ready        (gen_ready),
        .gen_data         (gen_data),
        .gen_last         (gen_last),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload_data  (tx_payload_data),
        .tx_payload_last  (tx_payload_last)
    );

endmodule

`default_nettype wire

// File: udp_pattern_source.f
source/cmd_pkg.sv
source/stream_pkg.sv
source/cmd_rx_filter.sv
source/cmd_decoder.sv
source/pattern_burst_gen.sv
source/tx_frame_buffer.sv
source/udp_pattern_source.sv
dv/tb_udp_pattern_source.sv
